// File: tb.f
+incdir+hw
hw/fifo_pkg.sv
hw/fifo_mem.sv
hw/fifo_wr_ctrl.sv
hw/fifo_rd_ctrl.sv
hw/async_fifo.sv
testbench/async_fifo_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
TOP       := async_fifo_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard hw/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/async_fifo_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "fifo_params.svh"

module async_fifo_tb
   import fifo_pkg::*;
();

   localparam int DRIVE_DELAY  = 1;
   localparam int WAIT_LIMIT   = 200;
   localparam int RANDOM_WORDS = 300;
   localparam int RANDOM_LIMIT = 5000;

   logic       wclk;
   logic       rclk;
   logic       wrstn;
   logic       rrstn;
   logic       winc;
   logic       rinc;
   fifo_data_t wdata;
   logic       wfull;
   logic       rempty;
   fifo_data_t rdata;

   fifo_data_t  model [$]; // Accepted words, oldest first.
   int          wr_count      = 0;
   int          rd_count      = 0;
   int          err_count     = 0;
   int          timeout_count = 0;
   logic [31:0] lfsr_state;
   logic        writes_done;
   logic        rd_taken;
   fifo_data_t  exp_word;
   fifo_data_t  held_word;

   async_fifo async_fifo_i (
      .wclk   (wclk),
      .wrstn  (wrstn),
      .winc   (winc),
      .wdata  (wdata),
      .wfull  (wfull),
      .rclk   (rclk),
      .rrstn  (rrstn),
      .rinc   (rinc),
      .rempty (rempty),
      .rdata  (rdata)
   );

   always #2 rclk = ~rclk; // 4 ns.
   always #3 wclk = ~wclk; // 6 ns, unrelated to rclk.

   // ####################################################################
   // Stimulus helpers and reference model
   // ####################################################################

   function automatic logic take_bit();
      logic b;
      b          = lfsr_state[0];
      lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
      return b;
   endfunction

   function automatic fifo_data_t random_word();
      fifo_data_t w;
      for (int i = 0; i < `FIFO_WIDTH; i++) begin
         w[i] = take_bit();
      end
      return w;
   endfunction

   // Oldest accepted word still waiting.
   function automatic fifo_data_t expected_word();
      return model.pop_front();
   endfunction

   task automatic next_wclk();
      @(posedge wclk);
      #DRIVE_DELAY;
   endtask

   task automatic next_rclk();
      @(posedge rclk);
      #DRIVE_DELAY;
   endtask

   // ####################################################################
   // Monitors and checker
   // ####################################################################

   always @(posedge wclk) begin
      if (wrstn && winc && !wfull) begin
         model.push_back(wdata);
         wr_count++;
      end
   end

   // Reads sampled on the rising edge and checked on the falling one.
   always @(posedge rclk) begin
      rd_taken = rrstn && rinc && !rempty;
      @(negedge rclk);
      if (rd_taken) begin
         rd_count++;
         if (model.size() == 0) begin
            err_count++;
            $display("read accepted at %0t ns while no word was outstanding", $time);
         end else begin
            exp_word = expected_word();
            assert (rdata == exp_word)
            else begin
               err_count++;
               $display("error at %0t ns: rdata expected %h, got %h", $time, exp_word, rdata);
            end
         end
      end else if (rrstn) begin
         assert (rdata == held_word)
         else begin
            err_count++;
            $display("error at %0t ns: rdata moved from %h to %h with no read",
                     $time, held_word, rdata);
         end
      end
      held_word = rdata;
   end

   // ####################################################################
   // Test phases
   // ####################################################################

   task automatic fill_until_full();
      int start;
      int cycles;
      start  = wr_count;
      cycles = 0;
      next_wclk();
      winc  = 1'b1;
      wdata = random_word();
      while (!wfull && cycles < WAIT_LIMIT) begin
         next_wclk();
         wdata = random_word();
         cycles++;
      end
      if (!wfull) begin
         timeout_count++;
         $display("timeout at %0t ns: wfull never rose while filling", $time);
      end
      assert (wr_count - start == `FIFO_DEPTH)
      else begin
         err_count++;
         $display("error at %0t ns: %0d writes taken before full", $time, wr_count - start);
      end
      repeat (6) begin
         next_wclk();
         winc  = ~winc; // Pulses against a full FIFO.
         wdata = random_word();
      end
      next_wclk();
      winc = 1'b0;
      assert (wfull && wr_count - start == `FIFO_DEPTH)
      else begin
         err_count++;
         $display("error at %0t ns: write slipped in while full", $time);
      end
   endtask

   task automatic drain_until_empty();
      int start;
      int cycles;
      cycles = 0;
      next_rclk();
      while (rempty && cycles < WAIT_LIMIT) begin
         next_rclk();
         cycles++;
      end
      if (rempty) begin
         timeout_count++;
         $display("timeout at %0t ns: rempty never fell after the fill", $time);
      end
      start  = rd_count;
      cycles = 0;
      rinc   = 1'b1;
      next_rclk();
      while (!rempty && cycles < WAIT_LIMIT) begin
         next_rclk();
         cycles++;
      end
      if (!rempty) begin
         timeout_count++;
         $display("timeout at %0t ns: rempty never rose while draining", $time);
      end
      // Keep asking while empty.
      repeat (8) begin
         next_rclk();
         assert (rempty)
         else begin
            err_count++;
            $display("error at %0t ns: rempty fell with nothing written", $time);
         end
      end
      rinc = 1'b0;
      assert (rd_count - start == `FIFO_DEPTH && model.size() == 0)
      else begin
         err_count++;
         $display("error at %0t ns: %0d reads in the drain", $time, rd_count - start);
      end
   endtask

   task automatic random_traffic();
      int start;
      int wcycles;
      int rcycles;
      start       = wr_count;
      wcycles     = 0;
      rcycles     = 0;
      writes_done = 1'b0;
      fork
         begin
            while (wr_count - start < RANDOM_WORDS && wcycles < RANDOM_LIMIT) begin
               next_wclk();
               winc  = take_bit();
               wdata = random_word();
               wcycles++;
            end
            winc        = 1'b0;
            writes_done = 1'b1;
         end
         begin
            while (!(writes_done && model.size() == 0) && rcycles < RANDOM_LIMIT) begin
               next_rclk();
               rinc = take_bit();
               rcycles++;
            end
            rinc = 1'b0;
         end
      join
      if (wr_count - start < RANDOM_WORDS) begin
         timeout_count++;
         $display("timeout at %0t ns: writer never placed all its words", $time);
      end
      if (model.size() != 0) begin
         timeout_count++;
         $display("timeout at %0t ns: %0d words never came out", $time, model.size());
      end
      assert (rd_count == wr_count)
      else begin
         err_count++;
         $display("error at %0t ns: %0d written, %0d read", $time, wr_count, rd_count);
      end
   endtask

   initial begin
      lfsr_state  = 32'hb6b5f534;
      rclk        = 1'b0;
      wclk        = 1'b0;
      rrstn       = 1'b0;
      wrstn       = 1'b0;
      winc        = 1'b0;
      rinc        = 1'b0;
      wdata       = '0;
      writes_done = 1'b0;
      held_word   = '0;
      exp_word    = '0;

      repeat (4) @(posedge rclk);
      #DRIVE_DELAY;
      rrstn = 1'b1;
      next_wclk();
      wrstn = 1'b1;

      assert (rempty && !wfull && rdata == '0)
      else begin
         err_count++;
         $display("error at %0t ns: after reset rempty=%b wfull=%b rdata=%h",
                  $time, rempty, wfull, rdata);
      end

      fill_until_full();
      drain_until_empty();
      random_traffic();

      $display("mismatches: %0d, timeouts: %0d", err_count, timeout_count);
      if (err_count == 0 && timeout_count == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: hw/async_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "fifo_params.svh"

module async_fifo
   import fifo_pkg::*;
(
   // Producer side.
   input  wire logic       wclk,
   input  wire logic       wrstn,
   input  wire logic       winc,
   input  wire fifo_data_t wdata,
   output logic            wfull,

   // Consumer side.
   input  wire logic       rclk,
   input  wire logic       rrstn,
   input  wire logic       rinc,
   output logic            rempty,
   output fifo_data_t      rdata
);

   logic                wen;
   logic                ren;
   logic [`FIFO_AW-1:0] waddr;
   logic [`FIFO_AW-1:0] raddr;
   fifo_ptr_t           wptr_gray; // Crosses into rclk.
   fifo_ptr_t           rptr_gray; // Crosses into wclk.

   // ####################################################################
   // Controllers
   // ####################################################################

   fifo_wr_ctrl fifo_wr_ctrl_i (
      .wclk      (wclk),
      .wrstn     (wrstn),
      .winc      (winc),
      .rptr_gray (rptr_gray),
      .wptr_gray (wptr_gray),
      .wen       (wen),
      .waddr     (waddr),
      .wfull     (wfull)
   );

   fifo_rd_ctrl fifo_rd_ctrl_i (
      .rclk      (rclk),
      .rrstn     (rrstn),
      .rinc      (rinc),
      .wptr_gray (wptr_gray),
      .rptr_gray (rptr_gray),
      .ren       (ren),
      .raddr     (raddr),
      .rempty    (rempty)
   );

   // ####################################################################
   // Storage
   // ####################################################################

   fifo_mem #(
      .data_t (fifo_data_t),
      .DEPTH  (`FIFO_DEPTH)
   ) fifo_mem_i (
      .wclk   (wclk),
      .wen    (wen),
      .waddr  (waddr),
      .wdata  (wdata), // Straight from the producer.
      .rclk   (rclk),
      .rrstn  (rrstn),
      .ren    (ren),
      .raddr  (raddr),
      .rdata  (rdata)
   );

endmodule

`default_nettype wire

// File: hw/fifo_rd_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "fifo_params.svh"

module fifo_rd_ctrl
   import fifo_pkg::*;
(
   input  wire logic                rclk,
   input  wire logic                rrstn,
   input  wire logic                rinc,
   input  wire fifo_ptr_t           wptr_gray, // From wclk domain.
   output fifo_ptr_t                rptr_gray,
   output logic                     ren,
   output logic [`FIFO_AW-1:0]      raddr,
   output logic                     rempty
);

   fifo_ptr_t rbin;
   fifo_ptr_t rbin_next;
   fifo_ptr_t rgray_next;
   fifo_ptr_t wq1_gray;
   fifo_ptr_t wq2_gray;

   // ####################################################################
   // Read pointer
   // ####################################################################

   assign ren        = rinc & ~rempty;
   assign rbin_next  = rbin + fifo_ptr_t'(ren);
   assign rgray_next = (rbin_next >> 1) ^ rbin_next;

   always_ff @(posedge rclk or negedge rrstn) begin
      if (!rrstn) begin
         rbin      <= '0;
         rptr_gray <= '0;
      end else begin
         rbin      <= rbin_next;
         rptr_gray <= rgray_next; // Seen by the write side.
      end
   end

   assign raddr = rbin[`FIFO_AW-1:0];

   // ####################################################################
   // Write pointer synchronizer
   // ####################################################################

   // Two flops, rclk domain.
   always_ff @(posedge rclk or negedge rrstn) begin
      if (!rrstn) begin
         wq1_gray <= '0;
         wq2_gray <= '0;
      end else begin
         wq1_gray <= wptr_gray;
         wq2_gray <= wq1_gray;
      end
   end

   // Empty on exact match, including the wrap bit.
   assign rempty = (rptr_gray == wq2_gray);

   // ####################################################################
   // Checks
   // ####################################################################

   // Nothing popped while empty.
   a_no_read_empty: assert property (@(posedge rclk) disable iff (!rrstn)
      rempty |=> $stable(rptr_gray));

   a_rgray_step: assert property (@(posedge rclk) disable iff (!rrstn)
      $countones(rptr_gray ^ $past(rptr_gray)) <= 1); // One bit per cycle.

endmodule

`default_nettype wire

// File: hw/fifo_wr_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "fifo_params.svh"

module fifo_wr_ctrl
   import fifo_pkg::*;
(
   input  wire logic                wclk,
   input  wire logic                wrstn,
   input  wire logic                winc,
   input  wire fifo_ptr_t           rptr_gray, // From rclk domain.
   output fifo_ptr_t                wptr_gray,
   output logic                     wen,
   output logic [`FIFO_AW-1:0]      waddr,
   output logic                     wfull
);

   fifo_ptr_t wbin;
   fifo_ptr_t wbin_next;
   fifo_ptr_t wgray_next;
   fifo_ptr_t rq1_gray;
   fifo_ptr_t rq2_gray;

   // ####################################################################
   // Write pointer
   // ####################################################################

   assign wen        = winc & ~wfull;
   assign wbin_next  = wbin + fifo_ptr_t'(wen);
   assign wgray_next = (wbin_next >> 1) ^ wbin_next; // Binary to Gray.

   // Binary and Gray copies move on the same edge.
   always_ff @(posedge wclk or negedge wrstn) begin
      if (!wrstn) begin
         wbin      <= '0;
         wptr_gray <= '0;
      end else begin
         wbin      <= wbin_next;
         wptr_gray <= wgray_next;
      end
   end

   assign waddr = wbin[`FIFO_AW-1:0]; // Wrap bit dropped.

   // ####################################################################
   // Read pointer synchronizer
   // ####################################################################

   always_ff @(posedge wclk or negedge wrstn) begin
      if (!wrstn) begin
         rq1_gray <= '0;
         rq2_gray <= '0;
      end else begin
         rq1_gray <= rptr_gray;
         rq2_gray <= rq1_gray;
      end
   end

   // Full when the Gray pointers differ only in the two top bits.
   assign wfull = (wptr_gray == {~rq2_gray[`FIFO_AW -: 2], rq2_gray[`FIFO_AW-2:0]});

   // ####################################################################
   // Checks
   // ####################################################################

   // No write slips in while full.
   a_no_write_full: assert property (@(posedge wclk) disable iff (!wrstn)
      wfull |=> $stable(wptr_gray));

   // Gray pointer steps one bit at a time.
   a_wgray_step: assert property (@(posedge wclk) disable iff (!wrstn)
      $countones(wptr_gray ^ $past(wptr_gray)) <= 1);

endmodule

`default_nettype wire

// File: hw/fifo_mem.sv
`timescale 1ns/10ps
`default_nettype none

`include "fifo_params.svh"

module fifo_mem
   import fifo_pkg::*;
#(
   parameter type data_t = fifo_data_t,
   parameter int  DEPTH  = `FIFO_DEPTH
) (
   // Write port.
   input  wire logic               wclk,
   input  wire logic               wen,
   input  wire logic [`FIFO_AW-1:0] waddr,
   input  wire data_t              wdata,

   // Read port.
   input  wire logic               rclk,
   input  wire logic               rrstn,
   input  wire logic               ren,
   input  wire logic [`FIFO_AW-1:0] raddr,
   output data_t                   rdata
);

   data_t mem [DEPTH];

   // ####################################################################
   // Write side, wclk domain
   // ####################################################################

   always_ff @(posedge wclk) begin
      if (wen) begin
         mem[waddr] <= wdata; // Already qualified by the write controller.
      end
   end

   // ####################################################################
   // Registered read, rclk domain
   // ####################################################################

   // Word appears one rclk after the accepted read and holds until the next.
   always_ff @(posedge rclk or negedge rrstn) begin
      if (!rrstn) begin
         rdata <= '0;
      end else if (ren) begin
         rdata <= mem[raddr];
      end
   end

endmodule

`default_nettype wire

// File: hw/fifo_pkg.sv
`default_nettype none

`include "fifo_params.svh"

package fifo_pkg;

   // ####################################################################
   // Payload and pointer types
   // ####################################################################

   // One FIFO word.
   typedef logic [`FIFO_WIDTH-1:0] fifo_data_t;

   // Address plus wrap bit.
   // Holds either the binary or the Gray form of a pointer.
   typedef logic [`FIFO_AW:0] fifo_ptr_t;

endpackage

`default_nettype wire

// File: hw/fifo_params.svh
`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

// ####################################################################
// FIFO geometry
// ####################################################################

// Data bits per word.
`define FIFO_WIDTH 8

// Number of words, power of two.
`define FIFO_DEPTH 16

`define FIFO_AW ($clog2(`FIFO_DEPTH)) // Address bits.

`endif
